/* include/mem_region_defines.svh */
`ifndef MEM_REGION_DEFINES_SVH
`define MEM_REGION_DEFINES_SVH

// word address widths of the two RAMs.
`define MR_INSTR_AW   12
`define MR_DATA_AW    11

// top address byte of each window.
`define MR_INSTR_TAG  8'h1C
`define MR_DATA_TAG   8'h10

// address and data bus width.
`define MR_BUS_W      32

`endif

/* hdl/mem_region_pkg.sv */
`include "mem_region_defines.svh"

package mem_region_pkg;

  typedef logic [`MR_BUS_W-1:0]   addr_t;
  typedef logic [`MR_BUS_W-1:0]   word_t;
  typedef logic [`MR_BUS_W/8-1:0] be_t;

  // one request on any req/gnt/rvalid port, 69 bits.
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
  } mem_req_t;

  // rdata only meaningful with rvalid.
  typedef struct packed {
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

  // owner of the last granted core data request.
  typedef enum logic [1:0] {
    DMX_RAM,
    DMX_EXT
  } demux_state_e;

endpackage

/* hdl/dp_ram.sv */
`timescale 1ns/1ps

module dp_ram
  import mem_region_pkg::*;
#(
  parameter int ADDR_WIDTH = 10
)
(
  input  logic                  clk,

  input  logic                  en_a_i,
  input  logic                  we_a_i,
  input  logic [ADDR_WIDTH-1:0] addr_a_i,
  input  word_t                 wdata_a_i,
  input  be_t                   be_a_i,
  output word_t                 rdata_a_o,

  input  logic                  en_b_i,
  input  logic                  we_b_i,
  input  logic [ADDR_WIDTH-1:0] addr_b_i,
  input  word_t                 wdata_b_i,
  input  be_t                   be_b_i,
  output word_t                 rdata_b_o
);

  word_t mem [2**ADDR_WIDTH];

  // both ports in one process, port b wins a same-word collision.
  always_ff @(posedge clk)
  begin
    if (en_a_i)
    begin
      rdata_a_o <= mem[addr_a_i]; // read before write.
      if (we_a_i)
        for (int i = 0; i < $bits(be_t); i++)
          if (be_a_i[i])
            mem[addr_a_i][i*8 +: 8] <= wdata_a_i[i*8 +: 8];
    end

    if (en_b_i)
    begin
      rdata_b_o <= mem[addr_b_i];
      if (we_b_i)
        for (int i = 0; i < $bits(be_t); i++)
          if (be_b_i[i])
            mem[addr_b_i][i*8 +: 8] <= wdata_b_i[i*8 +: 8];
    end
  end

endmodule

/* hdl/data_port_demux.sv */
`timescale 1ns/1ps
`include "mem_region_defines.svh"

module data_port_demux
  import mem_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     core_req_i,
  input  mem_req_t core_req_data_i,
  output logic     core_gnt_o,
  output mem_rsp_t core_rsp_o,

  output logic     ram_en_o,
  input  word_t    ram_rdata_i,

  output logic     ext_req_o,
  input  logic     ext_gnt_i,
  input  mem_rsp_t ext_rsp_i
);

  logic         is_local;
  logic         rsp_done;
  logic         block_ram;
  logic         block_ext;
  logic         ext_accept;
  logic         ram_rvalid_q;
  logic         pending_q;
  demux_state_e state_q;
  demux_state_e state_d;

  assign is_local = (core_req_data_i.addr[31:24] == `MR_DATA_TAG);

  // a switch of target waits until the response in flight returns.
  assign rsp_done  = core_rsp_o.rvalid;
  assign block_ram = pending_q & ~rsp_done & (state_q != DMX_RAM);
  assign block_ext = pending_q & ~rsp_done & (state_q != DMX_EXT);

  assign ram_en_o   = core_req_i & is_local & ~block_ram; // ram grants at once.
  assign ext_req_o  = core_req_i & ~is_local & ~block_ext;
  assign ext_accept = ext_req_o & ext_gnt_i;
  assign core_gnt_o = ram_en_o | ext_accept;

  always_comb
  begin
    state_d = state_q;
    if (ram_en_o)
      state_d = DMX_RAM;
    else if (ext_accept)
      state_d = DMX_EXT;
  end

  always_comb
  begin
    case (state_q)
      DMX_EXT: core_rsp_o = ext_rsp_i;
      default: core_rsp_o = '{rvalid: ram_rvalid_q, rdata: ram_rdata_i};
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= DMX_RAM;
      pending_q    <= 1'b0;
      ram_rvalid_q <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      pending_q    <= core_gnt_o | (pending_q & ~rsp_done);
      ram_rvalid_q <= ram_en_o;
    end
  end

endmodule

/* hdl/ext_bus_bridge.sv */
`timescale 1ns/1ps

module ext_bus_bridge
  import mem_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     req_i,
  input  mem_req_t req_data_i,
  output logic     gnt_o,
  output mem_rsp_t rsp_o,

  output logic     ext_m_req_o,
  output mem_req_t ext_m_req_data_o,
  input  logic     ext_m_gnt_i,
  input  mem_rsp_t ext_m_rsp_i
);

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_REQ,
    BR_WAIT
  } br_state_e;

  br_state_e state_q;
  logic      busy;
  logic      rsp_valid_q;
  word_t     rsp_data_q;
  mem_req_t  req_q;

  assign busy  = (state_q != BR_IDLE);
  assign gnt_o = ~busy; // one request at a time.

  assign ext_m_req_o      = (state_q == BR_REQ);
  assign ext_m_req_data_o = req_q;
  assign rsp_o            = '{rvalid: rsp_valid_q, rdata: rsp_data_q};

  // ------------------------------------------------------------------------
  // request phase, then wait for the response
  // ------------------------------------------------------------------------
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= BR_IDLE;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      rsp_valid_q <= (state_q == BR_WAIT) & ext_m_rsp_i.rvalid;
      case (state_q)
        BR_IDLE: if (req_i) state_q <= BR_REQ;
        BR_REQ:  if (ext_m_gnt_i) state_q <= BR_WAIT;
        BR_WAIT: if (ext_m_rsp_i.rvalid) state_q <= BR_IDLE;
        default: state_q <= BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_i && gnt_o)
      req_q <= req_data_i;
    if ((state_q == BR_WAIT) && ext_m_rsp_i.rvalid)
      rsp_data_q <= ext_m_rsp_i.rdata;
  end

endmodule

/* hdl/mem_slave_port.sv */
`timescale 1ns/1ps
`include "mem_region_defines.svh"

module mem_slave_port
  import mem_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     s_req_i,
  input  mem_req_t s_req_data_i,
  output logic     s_gnt_o,
  output mem_rsp_t s_rsp_o,

  output logic     instr_en_o,
  output logic     data_en_o,
  input  word_t    instr_rdata_i,
  input  word_t    data_rdata_i
);

  logic instr_hit;
  logic data_hit;
  logic rvalid_q;
  logic instr_sel_q;
  logic data_sel_q;

  assign instr_hit = (s_req_data_i.addr[31:24] == `MR_INSTR_TAG);
  assign data_hit  = (s_req_data_i.addr[31:24] == `MR_DATA_TAG);

  assign s_gnt_o    = s_req_i;
  assign instr_en_o = s_req_i & instr_hit;
  assign data_en_o  = s_req_i & data_hit; // misses never reach a RAM.

  always_comb
  begin
    s_rsp_o.rvalid = rvalid_q;
    if (instr_sel_q)
      s_rsp_o.rdata = instr_rdata_i;
    else if (data_sel_q)
      s_rsp_o.rdata = data_rdata_i;
    else
      s_rsp_o.rdata = '0;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid_q    <= 1'b0;
      instr_sel_q <= 1'b0;
      data_sel_q  <= 1'b0;
    end
    else
    begin
      rvalid_q    <= s_req_i;
      instr_sel_q <= instr_en_o;
      data_sel_q  <= data_en_o;
    end
  end

endmodule

/* hdl/mem_region_top.sv */
`timescale 1ns/1ps
`include "mem_region_defines.svh"

module mem_region_top
  import mem_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     instr_req_i,
  input  addr_t    instr_addr_i,
  output logic     instr_rvalid_o,
  output word_t    instr_rdata_o,

  input  logic     core_req_i,
  input  mem_req_t core_req_data_i,
  output logic     core_gnt_o,
  output mem_rsp_t core_rsp_o,

  output logic     ext_m_req_o,
  output mem_req_t ext_m_req_data_o,
  input  logic     ext_m_gnt_i,
  input  mem_rsp_t ext_m_rsp_i,

  input  logic     s_req_i,
  input  mem_req_t s_req_data_i,
  output logic     s_gnt_o,
  output mem_rsp_t s_rsp_o
);

  logic     instr_en;
  logic     ram_en;
  word_t    ram_rdata;
  logic     ext_req;
  logic     ext_gnt;
  mem_rsp_t ext_rsp;
  logic     s_instr_en;
  logic     s_data_en;
  word_t    s_instr_rdata;
  word_t    s_data_rdata;

  // ------------------------------------------------------------------------
  // instruction fetch
  // ------------------------------------------------------------------------
  assign instr_en = instr_req_i & (instr_addr_i[31:24] == `MR_INSTR_TAG);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      instr_rvalid_o <= 1'b0;
    else
      instr_rvalid_o <= instr_en;
  end

  dp_ram #(.ADDR_WIDTH(`MR_INSTR_AW)) i_instr_ram (
    .clk       ( clk                                          ),
    .en_a_i    ( instr_en                                     ),
    .we_a_i    ( 1'b0                                         ), // fetch is read only.
    .addr_a_i  ( instr_addr_i[`MR_INSTR_AW+1:2]               ),
    .wdata_a_i ( '0                                           ),
    .be_a_i    ( '0                                           ),
    .rdata_a_o ( instr_rdata_o                                ),
    .en_b_i    ( s_instr_en                                   ),
    .we_b_i    ( s_req_data_i.we                              ),
    .addr_b_i  ( s_req_data_i.addr[`MR_INSTR_AW+1:2]          ),
    .wdata_b_i ( s_req_data_i.wdata                           ),
    .be_b_i    ( s_req_data_i.be                              ),
    .rdata_b_o ( s_instr_rdata                                )
  );

  // ------------------------------------------------------------------------
  // core data path
  // ------------------------------------------------------------------------
  data_port_demux i_demux (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .core_req_i      ( core_req_i      ),
    .core_req_data_i ( core_req_data_i ),
    .core_gnt_o      ( core_gnt_o      ),
    .core_rsp_o      ( core_rsp_o      ),
    .ram_en_o        ( ram_en          ),
    .ram_rdata_i     ( ram_rdata       ),
    .ext_req_o       ( ext_req         ),
    .ext_gnt_i       ( ext_gnt         ),
    .ext_rsp_i       ( ext_rsp         )
  );

  ext_bus_bridge i_bridge (
    .clk              ( clk              ),
    .rst_n            ( rst_n            ),
    .req_i            ( ext_req          ),
    .req_data_i       ( core_req_data_i  ),
    .gnt_o            ( ext_gnt          ),
    .rsp_o            ( ext_rsp          ),
    .ext_m_req_o      ( ext_m_req_o      ),
    .ext_m_req_data_o ( ext_m_req_data_o ),
    .ext_m_gnt_i      ( ext_m_gnt_i      ),
    .ext_m_rsp_i      ( ext_m_rsp_i      )
  );

  dp_ram #(.ADDR_WIDTH(`MR_DATA_AW)) i_data_ram (
    .clk       ( clk                                    ),
    .en_a_i    ( ram_en                                 ),
    .we_a_i    ( core_req_data_i.we                     ),
    .addr_a_i  ( core_req_data_i.addr[`MR_DATA_AW+1:2]  ),
    .wdata_a_i ( core_req_data_i.wdata                  ),
    .be_a_i    ( core_req_data_i.be                     ),
    .rdata_a_o ( ram_rdata                              ),
    .en_b_i    ( s_data_en                              ),
    .we_b_i    ( s_req_data_i.we                        ),
    .addr_b_i  ( s_req_data_i.addr[`MR_DATA_AW+1:2]     ),
    .wdata_b_i ( s_req_data_i.wdata                     ),
    .be_b_i    ( s_req_data_i.be                        ),
    .rdata_b_o ( s_data_rdata                           )
  );

  // loader access to port b of both RAMs.
  mem_slave_port i_slave (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .s_req_i       ( s_req_i       ),
    .s_req_data_i  ( s_req_data_i  ),
    .s_gnt_o       ( s_gnt_o       ),
    .s_rsp_o       ( s_rsp_o       ),
    .instr_en_o    ( s_instr_en    ),
    .data_en_o     ( s_data_en     ),
    .instr_rdata_i ( s_instr_rdata ),
    .data_rdata_i  ( s_data_rdata  )
  );

endmodule

/* verif/mem_region_checker.sv */
`timescale 1ns/1ps
`include "mem_region_defines.svh"

module mem_region_checker
  import mem_region_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  int       test_id_i,
  input  word_t    test_exp_i,
  input  logic     instr_req_i,
  input  addr_t    instr_addr_i,
  input  logic     instr_rvalid_i,
  input  word_t    instr_rdata_i,
  input  logic     core_req_i,
  input  mem_req_t core_req_data_i,
  input  logic     core_gnt_i,
  input  mem_rsp_t core_rsp_i,
  input  logic     ext_m_req_i,
  input  mem_req_t ext_m_req_data_i,
  input  logic     ext_m_gnt_i,
  input  logic     s_req_i,
  input  mem_req_t s_req_data_i,
  input  logic     s_gnt_i,
  input  mem_rsp_t s_rsp_i,
  output int       pass_cnt_o,
  output int       fail_cnt_o,
  output int       pending_o
);

  // one accepted access waiting for its response.
  typedef struct packed {
    int    id;
    logic  we;
    word_t exp;
    word_t model;
  } pend_t;

  typedef struct packed {
    int       id;
    mem_req_t req;
  } ext_t;

  pend_t instr_q [$];
  pend_t core_q [$];
  pend_t slave_q [$];
  ext_t  ext_q [$];
  word_t shadow [addr_t]; // keyed by word-aligned address.
  logic  miss_v = 1'b0;
  int    miss_id;

  function automatic logic in_ram(input addr_t a);
    return (a[31:24] == `MR_DATA_TAG) || (a[31:24] == `MR_INSTR_TAG);
  endfunction

  // read data expected under the address map.
  function automatic word_t model_read(input logic core, input addr_t a);
    if (core && (a[31:24] != `MR_DATA_TAG))
      return a ^ 32'hA5A5_A5A5; // external agent answer.
    if (!in_ram(a))
      return '0;
    if (shadow.exists({a[31:2], 2'b00}))
      return shadow[{a[31:2], 2'b00}];
    return 'x;
  endfunction

  task automatic model_write(input mem_req_t r);
    word_t w;
    w = model_read(1'b0, r.addr);
    for (int i = 0; i < 4; i++)
      if (r.be[i])
        w[i*8 +: 8] = r.wdata[i*8 +: 8];
    shadow[{r.addr[31:2], 2'b00}] = w;
  endtask

  function automatic pend_t make_pend(input logic core, input logic we, input addr_t a);
    pend_t p;
    p.id    = test_id_i;
    p.we    = we;
    p.exp   = test_exp_i;
    p.model = model_read(core, a);
    return p;
  endfunction

  task automatic report(input pend_t p, input word_t act, input string port);
    if (p.we || ((act === p.exp) && (act === p.model)))
    begin
      pass_cnt_o++;
      $display("test %0d %s ok", p.id, port);
    end
    else
    begin
      fail_cnt_o++;
      $display("** Error test %0d %s: expected %h actual %h", p.id, port, p.exp, act);
      if (p.exp !== p.model)
        $display("test %0d: vector value %h differs from the memory model %h",
                 p.id, p.exp, p.model);
    end
  endtask

  task automatic note_failure(input string msg);
    fail_cnt_o++;
    $display("%s", msg);
  endtask

  always @(posedge clk)
  begin
    ext_t ext_e;
    if (rst_n)
    begin
      // ------------------------------------------------------------------------
      // responses first, they belong to earlier accepts
      // ------------------------------------------------------------------------
      if (instr_rvalid_i)
      begin
        if (instr_q.size() > 0)
          report(instr_q.pop_front(), instr_rdata_i, "fetch");
        else
          note_failure($sformatf("test %0d: fetch outside the window returned data", miss_id));
      end
      else if (miss_v)
      begin
        pass_cnt_o++;
        $display("test %0d fetch miss ok", miss_id);
      end

      if (core_rsp_i.rvalid)
      begin
        if (core_q.size() > 0)
          report(core_q.pop_front(), core_rsp_i.rdata, "core");
        else
          note_failure("core port gave rvalid with no request outstanding");
      end

      if (s_rsp_i.rvalid)
      begin
        if (slave_q.size() > 0)
          report(slave_q.pop_front(), s_rsp_i.rdata, "slave");
        else
          note_failure("slave port gave rvalid with no request outstanding");
      end

      if (ext_m_req_i && ext_m_gnt_i && (ext_q.size() == 0))
        note_failure("external bus request with no core request behind it");
      else if (ext_m_req_i && ext_m_gnt_i)
      begin
        ext_e = ext_q.pop_front();
        if (ext_e.req !== ext_m_req_data_i)
        begin
          fail_cnt_o++;
          $display("** Error test %0d ext_bus: expected %h actual %h",
                   ext_e.id, ext_e.req, ext_m_req_data_i);
        end
      end

      // ------------------------------------------------------------------------
      // accepted requests
      // ------------------------------------------------------------------------
      miss_v  = instr_req_i && (instr_addr_i[31:24] != `MR_INSTR_TAG);
      miss_id = test_id_i;
      if (instr_req_i && !miss_v)
        instr_q.push_back(make_pend(1'b0, 1'b0, instr_addr_i));

      if (core_req_i && core_gnt_i)
      begin
        core_q.push_back(make_pend(1'b1, core_req_data_i.we, core_req_data_i.addr));
        if (core_req_data_i.addr[31:24] != `MR_DATA_TAG)
          ext_q.push_back('{id: test_id_i, req: core_req_data_i});
        else if (core_req_data_i.we)
          model_write(core_req_data_i);
      end

      if (s_req_i && s_gnt_i)
      begin
        slave_q.push_back(make_pend(1'b0, s_req_data_i.we, s_req_data_i.addr));
        if (s_req_data_i.we && in_ram(s_req_data_i.addr))
          model_write(s_req_data_i); // misses are dropped.
      end

      pending_o = instr_q.size() + core_q.size() + slave_q.size() + ext_q.size()
                  + int'(miss_v);
    end
  end

endmodule

/* verif/mem_region_tb.sv */
`timescale 1ns/1ps

module mem_region_tb
  import mem_region_pkg::*;
();

  localparam int VEC_MAX = 64;
  localparam int CLK_NS  = 20;

  logic     clk;
  logic     rst_n;
  logic     instr_req;
  addr_t    instr_addr;
  logic     instr_rvalid;
  word_t    instr_rdata;
  logic     core_req;
  mem_req_t core_req_data;
  logic     core_gnt;
  mem_rsp_t core_rsp;
  logic     ext_m_req;
  mem_req_t ext_m_req_data;
  logic     ext_m_gnt;
  mem_rsp_t ext_m_rsp;
  logic     s_req;
  mem_req_t s_req_data;
  logic     s_gnt;
  mem_rsp_t s_rsp;

  int       test_id;
  word_t    test_exp;
  int       pass_cnt;
  int       fail_cnt;
  int       pending;
  int       n_vec;
  int       limit_ns   = 0;
  int       ext_writes = 0;
  integer   seed       = 32'h6fe2_f4e2;
  word_t    vec_mem [VEC_MAX*6]; // six words per vector line.

  mem_region_top i_dut (
    .clk              ( clk            ),
    .rst_n            ( rst_n          ),
    .instr_req_i      ( instr_req      ),
    .instr_addr_i     ( instr_addr     ),
    .instr_rvalid_o   ( instr_rvalid   ),
    .instr_rdata_o    ( instr_rdata    ),
    .core_req_i       ( core_req       ),
    .core_req_data_i  ( core_req_data  ),
    .core_gnt_o       ( core_gnt       ),
    .core_rsp_o       ( core_rsp       ),
    .ext_m_req_o      ( ext_m_req      ),
    .ext_m_req_data_o ( ext_m_req_data ),
    .ext_m_gnt_i      ( ext_m_gnt      ),
    .ext_m_rsp_i      ( ext_m_rsp      ),
    .s_req_i          ( s_req          ),
    .s_req_data_i     ( s_req_data     ),
    .s_gnt_o          ( s_gnt          ),
    .s_rsp_o          ( s_rsp          )
  );

  mem_region_checker i_checker (
    .clk              ( clk            ),
    .rst_n            ( rst_n          ),
    .test_id_i        ( test_id        ),
    .test_exp_i       ( test_exp       ),
    .instr_req_i      ( instr_req      ),
    .instr_addr_i     ( instr_addr     ),
    .instr_rvalid_i   ( instr_rvalid   ),
    .instr_rdata_i    ( instr_rdata    ),
    .core_req_i       ( core_req       ),
    .core_req_data_i  ( core_req_data  ),
    .core_gnt_i       ( core_gnt       ),
    .core_rsp_i       ( core_rsp       ),
    .ext_m_req_i      ( ext_m_req      ),
    .ext_m_req_data_i ( ext_m_req_data ),
    .ext_m_gnt_i      ( ext_m_gnt      ),
    .s_req_i          ( s_req          ),
    .s_req_data_i     ( s_req_data     ),
    .s_gnt_i          ( s_gnt          ),
    .s_rsp_i          ( s_rsp          ),
    .pass_cnt_o       ( pass_cnt       ),
    .fail_cnt_o       ( fail_cnt       ),
    .pending_o        ( pending        )
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS/2) clk = ~clk;
  end

  task automatic drop_requests();
    instr_req = 1'b0;
    core_req  = 1'b0;
    s_req     = 1'b0;
  endtask

  // one vector line onto its port until granted.
  task automatic issue(input int idx);
    word_t    port;
    mem_req_t req;
    port      = vec_mem[idx*6];
    req.we    = vec_mem[idx*6+1][0];
    req.addr  = vec_mem[idx*6+2];
    req.be    = vec_mem[idx*6+3][3:0];
    req.wdata = vec_mem[idx*6+4];
    @(negedge clk);
    drop_requests();
    test_id  = idx;
    test_exp = vec_mem[idx*6+5];
    case (port)
      0:
      begin
        instr_req  = 1'b1;
        instr_addr = req.addr;
      end
      1:
      begin
        core_req      = 1'b1;
        core_req_data = req;
      end
      default:
      begin
        s_req      = 1'b1;
        s_req_data = req;
      end
    endcase
    @(posedge clk);
    while (((port == 1) && !core_gnt) || ((port == 2) && !s_gnt))
      @(posedge clk);
  endtask

  // --------------------------------------------------------------------------
  // outside agent on the external master bus
  // --------------------------------------------------------------------------
  initial
  begin
    int delay;
    ext_m_gnt = 1'b0;
    ext_m_rsp = '0;
    forever
    begin
      @(negedge clk);
      if (ext_m_req)
      begin
        delay = {$random(seed)} % 4; // grant after 0 to 3 cycles.
        repeat (delay) @(negedge clk);
        ext_m_gnt = 1'b1;
        @(negedge clk);
        ext_m_gnt        = 1'b0;
        ext_m_rsp.rvalid = 1'b1;
        ext_m_rsp.rdata  = ext_m_req_data.addr ^ 32'hA5A5_A5A5;
        if (ext_m_req_data.we)
          ext_writes++;
        @(negedge clk);
        ext_m_rsp = '0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // vector run
  // --------------------------------------------------------------------------
  initial
  begin
    rst_n         = 1'b0;
    instr_addr    = '0;
    core_req_data = '0;
    s_req_data    = '0;
    test_id       = 0;
    test_exp      = '0;
    drop_requests();
    foreach (vec_mem[i])
      vec_mem[i] = '1; // lines past the end carry no valid port.
    $readmemh("verif/mem_region_vectors.txt", vec_mem);
    n_vec = 0;
    while ((n_vec < VEC_MAX) && (vec_mem[n_vec*6] <= 2))
      n_vec++;
    limit_ns = (n_vec * 40 + 3 + 4) * CLK_NS;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_vec; i++)
      issue(i);
    @(negedge clk);
    drop_requests();
    while (pending != 0)
      @(negedge clk);
    repeat (2) @(negedge clk); // late stray responses.
    $display("passed %0d failed %0d external writes %0d", pass_cnt, fail_cnt, ext_writes);
    if ((n_vec > 0) && (fail_cnt == 0) && (pass_cnt == n_vec))
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("watchdog expired with %0d responses still missing", pending);
    $display("tests failed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
hdl/mem_region_pkg.sv
hdl/dp_ram.sv
hdl/data_port_demux.sv
hdl/ext_bus_bridge.sv
hdl/mem_slave_port.sv
hdl/mem_region_top.sv
verif/mem_region_checker.sv
verif/mem_region_tb.sv

/* verif/mem_region_vectors.txt */
// port (0 fetch, 1 core, 2 slave), op (0 read, 1 write), byte address,
// byte enables, write data, expected read data
2 1 1C000000 f 13579BDF 00000000
2 1 1C000004 f 2468ACE0 00000000
0 0 1C000000 f 00000000 13579BDF
0 0 1C000004 f 00000000 2468ACE0
0 0 20000000 f 00000000 00000000
1 1 10000004 f 11223344 00000000
1 1 10000004 5 AABBCCDD 00000000
1 1 10000008 f 55667788 00000000
1 0 10000004 f 00000000 11BB33DD
1 0 10000008 f 00000000 55667788
2 0 10000004 f 00000000 11BB33DD
2 1 10000008 8 99000000 00000000
1 0 10000008 f 00000000 99667788
1 1 30000000 f DEADBEEF 00000000
1 0 30000040 f 00000000 95A5A5E5
1 0 1C000008 f 00000000 B9A5A5AD
1 0 10000004 f 00000000 11BB33DD
1 0 40000004 f 00000000 E5A5A5A1
1 0 10000008 f 00000000 99667788
1 0 50000008 f 00000000 F5A5A5AD
2 1 60000004 f 12345678 00000000
2 0 60000004 f 00000000 00000000
2 0 10000004 f 00000000 11BB33DD
2 0 1C000004 f 00000000 2468ACE0
